// ==== logic/bank_pkg.sv ====
/*
 * Memory bank shared definitions
 * Default geometry of the bank, used by the RTL parameter headers and the testbench
 */

package bank_pkg;

  // ------------------------------------------------------------------------
  // Memory word and address geometry
  // ------------------------------------------------------------------------
  parameter int DEF_DATA_WIDTH = 32;       // Bits per memory word
  parameter int DEF_ADDR_WIDTH = 10;       // Depth is 2**DEF_ADDR_WIDTH words

  // ------------------------------------------------------------------------
  // Bank organisation
  // ------------------------------------------------------------------------
  parameter int DEF_NUM_MEMORIES = 4;      // Memories in the bank
  parameter int DEF_NUM_READ_PORTS = 2;    // Read ports seen from outside
  parameter int DEF_NUM_WRITE_PORTS = 2;   // Write ports seen from outside

endpackage

// ==== logic/port_map.sv ====
/*
 * Port map of the memory bank
 * Records for every memory its read and write port, and for every read port
 * the memory it returns data from. Commands take effect on the next cycle
 */

`timescale 1ns/1ps

module port_map #(
  parameter int NUM_MEMORIES    = bank_pkg::DEF_NUM_MEMORIES,
  parameter int NUM_READ_PORTS  = bank_pkg::DEF_NUM_READ_PORTS,
  parameter int NUM_WRITE_PORTS = bank_pkg::DEF_NUM_WRITE_PORTS,
  localparam int MEM_ID_WIDTH   = (NUM_MEMORIES > 1) ? $clog2(NUM_MEMORIES) : 1,
  localparam int RD_ID_WIDTH    = (NUM_READ_PORTS > 1) ? $clog2(NUM_READ_PORTS) : 1,
  localparam int WR_ID_WIDTH    = (NUM_WRITE_PORTS > 1) ? $clog2(NUM_WRITE_PORTS) : 1
) (
  input  logic                                clk,
  input  logic                                rst,           // Sync, active low
  input  logic                                cmd_assign,    // Tie memory to ports
  input  logic                                cmd_unassign,  // Release memory and port
  input  logic [MEM_ID_WIDTH-1:0]             memory,        // Memory operand
  input  logic [RD_ID_WIDTH-1:0]              read_port,     // Read port operand
  input  logic [WR_ID_WIDTH-1:0]              write_port,    // Write port operand
  output logic [NUM_MEMORIES*RD_ID_WIDTH-1:0] mem_read_sel,  // Read port of each memory
  output logic [NUM_MEMORIES-1:0]             mem_read_en,   // Memory has a read port
  output logic [NUM_MEMORIES*WR_ID_WIDTH-1:0] mem_write_sel, // Write port of each memory
  output logic [NUM_MEMORIES-1:0]             mem_write_en,  // Memory has a write port
  output logic [NUM_READ_PORTS*MEM_ID_WIDTH-1:0] port_mem_sel, // Memory of each read port
  output logic [NUM_READ_PORTS-1:0]           port_en        // Read port has a memory
);

  // ------------------------------------------------------------------------
  // Memory side table
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst) begin
      mem_read_sel  <= '0;
      mem_write_sel <= '0;
      mem_read_en   <= '0;
      mem_write_en  <= '0;
    end else if (cmd_assign) begin                                // Assign wins over unassign
      mem_read_sel[int'(memory)*RD_ID_WIDTH +: RD_ID_WIDTH]  <= read_port;
      mem_write_sel[int'(memory)*WR_ID_WIDTH +: WR_ID_WIDTH] <= write_port;
      mem_read_en[memory]  <= 1'b1;
      mem_write_en[memory] <= 1'b1;
    end else if (cmd_unassign) begin
      mem_read_en[memory]  <= 1'b0;                               // Selects kept, enables off
      mem_write_en[memory] <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Read port side table
  // ------------------------------------------------------------------------
  // A port keeps only its latest memory; an older memory may still hold
  // the port in its select, its results are simply not picked up
  always_ff @(posedge clk) begin
    if (!rst) begin
      port_mem_sel <= '0;
      port_en      <= '0;
    end else if (cmd_assign) begin
      port_mem_sel[int'(read_port)*MEM_ID_WIDTH +: MEM_ID_WIDTH] <= memory;
      port_en[read_port] <= 1'b1;
    end else if (cmd_unassign) begin
      port_en[read_port] <= 1'b0;                                 // Port returns zero from now
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  property p_cmd_in_range;
    @(posedge clk) disable iff (!rst)
      (cmd_assign || cmd_unassign) |->
        (int'(memory) < NUM_MEMORIES) && (int'(read_port) < NUM_READ_PORTS);
  endproperty

  a_cmd_in_range : assert property (p_cmd_in_range)
    else $error("port map command names a memory or read port out of range");

  property p_assign_write_port;
    @(posedge clk) disable iff (!rst)
      cmd_assign |-> (int'(write_port) < NUM_WRITE_PORTS);
  endproperty

  a_assign_write_port : assert property (p_assign_write_port)
    else $error("port map assign names a write port out of range");

endmodule

// ==== logic/write_switch.sv ====
/*
 * Write switch of the memory bank
 * Steers each write port's strobe, address and data to every memory mapped to it
 */

`timescale 1ns/1ps

module write_switch #(
  parameter int DATA_WIDTH      = bank_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH      = bank_pkg::DEF_ADDR_WIDTH,
  parameter int NUM_MEMORIES    = bank_pkg::DEF_NUM_MEMORIES,
  parameter int NUM_WRITE_PORTS = bank_pkg::DEF_NUM_WRITE_PORTS,
  localparam int WR_ID_WIDTH    = (NUM_WRITE_PORTS > 1) ? $clog2(NUM_WRITE_PORTS) : 1
) (
  input  logic [NUM_MEMORIES*WR_ID_WIDTH-1:0]   mem_write_sel,  // Write port of each memory
  input  logic [NUM_MEMORIES-1:0]               mem_write_en,   // Memory has a write port
  input  logic [NUM_WRITE_PORTS-1:0]            write_in,       // Write strobes from outside
  input  logic [NUM_WRITE_PORTS*ADDR_WIDTH-1:0] write_addr_in,
  input  logic [NUM_WRITE_PORTS*DATA_WIDTH-1:0] write_data_in,
  output logic [NUM_MEMORIES-1:0]               mem_write,      // Per memory strobe
  output logic [NUM_MEMORIES*ADDR_WIDTH-1:0]    mem_write_addr,
  output logic [NUM_MEMORIES*DATA_WIDTH-1:0]    mem_write_data
);

  // ------------------------------------------------------------------------
  // One mux per memory
  // ------------------------------------------------------------------------
  // Several memories may point at the same port and all of them see the
  // write, which gives the broadcast behaviour
  always_comb begin
    logic [WR_ID_WIDTH-1:0] sel;                                  // Port picked by memory m
    sel = '0;
    for (int m = 0; m < NUM_MEMORIES; m++) begin
      sel = mem_write_sel[m*WR_ID_WIDTH +: WR_ID_WIDTH];
      mem_write[m] = mem_write_en[m] & write_in[sel];             // Unmapped memory never writes
      mem_write_addr[m*ADDR_WIDTH +: ADDR_WIDTH] =
        write_addr_in[int'(sel)*ADDR_WIDTH +: ADDR_WIDTH];
      mem_write_data[m*DATA_WIDTH +: DATA_WIDTH] =
        write_data_in[int'(sel)*DATA_WIDTH +: DATA_WIDTH];        // Payload passes ungated
    end
  end

endmodule

// ==== logic/bank_memory.sv ====
/*
 * Simple dual-port memory of the bank
 * One write and one read port, registered read data in read-first mode and a
 * valid bit one cycle after each read strobe
 */

`timescale 1ns/1ps

module bank_memory #(
  parameter int DATA_WIDTH = bank_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = bank_pkg::DEF_ADDR_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst,         // Sync, active low
  input  logic                  write,       // Write strobe
  input  logic [ADDR_WIDTH-1:0] addr_write,
  input  logic [DATA_WIDTH-1:0] data_write,
  input  logic                  read,        // Read strobe
  input  logic [ADDR_WIDTH-1:0] addr_read,
  output logic [DATA_WIDTH-1:0] data_read,   // Held until the next read
  output logic                  valid_out    // One pulse per read
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] ram [DEPTH];         // Storage, no reset

  // ------------------------------------------------------------------------
  // Storage and read register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (write) begin
      ram[addr_write] <= data_write;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      data_read <= ram[addr_read];            // Old word on a same-address write
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_out <= 1'b0;
    end else begin
      valid_out <= read;
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  property p_valid_follows_read;
    @(posedge clk) disable iff (!rst)
      $past(rst) |-> (valid_out == $past(read));
  endproperty

  a_valid_follows_read : assert property (p_valid_follows_read)
    else $error("memory valid does not follow read strobe by one cycle");

endmodule

// ==== logic/read_switch.sv ====
/*
 * Read switch of the memory bank
 * Sends each read port's request to the memories mapped to it and returns to
 * each port the result of the memory the port has selected
 */

`timescale 1ns/1ps

module read_switch #(
  parameter int DATA_WIDTH     = bank_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH     = bank_pkg::DEF_ADDR_WIDTH,
  parameter int NUM_MEMORIES   = bank_pkg::DEF_NUM_MEMORIES,
  parameter int NUM_READ_PORTS = bank_pkg::DEF_NUM_READ_PORTS,
  localparam int MEM_ID_WIDTH  = (NUM_MEMORIES > 1) ? $clog2(NUM_MEMORIES) : 1,
  localparam int RD_ID_WIDTH   = (NUM_READ_PORTS > 1) ? $clog2(NUM_READ_PORTS) : 1
) (
  input  logic [NUM_MEMORIES*RD_ID_WIDTH-1:0]    mem_read_sel,  // Read port of each memory
  input  logic [NUM_MEMORIES-1:0]                mem_read_en,
  input  logic [NUM_READ_PORTS*MEM_ID_WIDTH-1:0] port_mem_sel,  // Memory of each read port
  input  logic [NUM_READ_PORTS-1:0]              port_en,
  input  logic [NUM_READ_PORTS-1:0]              read_in,       // Read strobes from outside
  input  logic [NUM_READ_PORTS*ADDR_WIDTH-1:0]   read_addr_in,
  input  logic [NUM_MEMORIES*DATA_WIDTH-1:0]     mem_data,      // Registered memory data
  input  logic [NUM_MEMORIES-1:0]                mem_valid,
  output logic [NUM_MEMORIES-1:0]                mem_read,      // Per memory strobe
  output logic [NUM_MEMORIES*ADDR_WIDTH-1:0]     mem_read_addr,
  output logic [NUM_READ_PORTS*DATA_WIDTH-1:0]   read_data_out,
  output logic [NUM_READ_PORTS-1:0]              read_valid_out
);

  // ------------------------------------------------------------------------
  // Request path, port to memories
  // ------------------------------------------------------------------------
  always_comb begin
    logic [RD_ID_WIDTH-1:0] rsel;                                 // Port picked by memory m
    rsel = '0;
    for (int m = 0; m < NUM_MEMORIES; m++) begin
      rsel = mem_read_sel[m*RD_ID_WIDTH +: RD_ID_WIDTH];
      mem_read[m] = mem_read_en[m] & read_in[rsel];
      mem_read_addr[m*ADDR_WIDTH +: ADDR_WIDTH] =
        read_addr_in[int'(rsel)*ADDR_WIDTH +: ADDR_WIDTH];
    end
  end

  // ------------------------------------------------------------------------
  // Result path, memory to port
  // ------------------------------------------------------------------------
  // Mapping is looked up when the result comes back, not when it was asked
  always_comb begin
    logic [MEM_ID_WIDTH-1:0] msel;                                // Memory picked by port p
    msel = '0;
    for (int p = 0; p < NUM_READ_PORTS; p++) begin
      msel = port_mem_sel[p*MEM_ID_WIDTH +: MEM_ID_WIDTH];
      if (port_en[p]) begin
        read_data_out[p*DATA_WIDTH +: DATA_WIDTH] =
          mem_data[int'(msel)*DATA_WIDTH +: DATA_WIDTH];
        read_valid_out[p] = mem_valid[msel];
      end else begin
        read_data_out[p*DATA_WIDTH +: DATA_WIDTH] = '0;             // Idle port reads as zero
        read_valid_out[p] = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < NUM_READ_PORTS; p++) begin
      a_no_valid_unmapped : assert (port_en[p] || !read_valid_out[p])
        else $error("read valid on port %0d without a memory", p);
    end
  end

endmodule

// ==== logic/memory_bank.sv ====
/*
 * Memory bank top level
 * A set of simple dual-port memories whose read and write ports are mapped to
 * the outside ports at run time by assign and unassign commands
 */

`timescale 1ns/1ps

module memory_bank #(
  parameter int DATA_WIDTH      = bank_pkg::DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH      = bank_pkg::DEF_ADDR_WIDTH,
  parameter int NUM_MEMORIES    = bank_pkg::DEF_NUM_MEMORIES,
  parameter int NUM_READ_PORTS  = bank_pkg::DEF_NUM_READ_PORTS,
  parameter int NUM_WRITE_PORTS = bank_pkg::DEF_NUM_WRITE_PORTS,
  localparam int MEM_ID_WIDTH   = (NUM_MEMORIES > 1) ? $clog2(NUM_MEMORIES) : 1,
  localparam int RD_ID_WIDTH    = (NUM_READ_PORTS > 1) ? $clog2(NUM_READ_PORTS) : 1,
  localparam int WR_ID_WIDTH    = (NUM_WRITE_PORTS > 1) ? $clog2(NUM_WRITE_PORTS) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst,           // Sync, active low
  // Mapping commands
  input  logic                                  cmd_assign,
  input  logic                                  cmd_unassign,
  input  logic [MEM_ID_WIDTH-1:0]               memory,
  input  logic [RD_ID_WIDTH-1:0]                read_port,
  input  logic [WR_ID_WIDTH-1:0]                write_port,
  // Write ports
  input  logic [NUM_WRITE_PORTS-1:0]            write_in,
  input  logic [NUM_WRITE_PORTS*ADDR_WIDTH-1:0] write_addr_in,
  input  logic [NUM_WRITE_PORTS*DATA_WIDTH-1:0] write_data_in,
  // Read ports
  input  logic [NUM_READ_PORTS-1:0]             read_in,
  input  logic [NUM_READ_PORTS*ADDR_WIDTH-1:0]  read_addr_in,
  output logic [NUM_READ_PORTS*DATA_WIDTH-1:0]  read_data_out, // One cycle after read_in
  output logic [NUM_READ_PORTS-1:0]             read_valid_out
);

  // ------------------------------------------------------------------------
  // Mapping state
  // ------------------------------------------------------------------------
  logic [NUM_MEMORIES*RD_ID_WIDTH-1:0]    mem_read_sel;
  logic [NUM_MEMORIES-1:0]                mem_read_en;
  logic [NUM_MEMORIES*WR_ID_WIDTH-1:0]    mem_write_sel;
  logic [NUM_MEMORIES-1:0]                mem_write_en;
  logic [NUM_READ_PORTS*MEM_ID_WIDTH-1:0] port_mem_sel;
  logic [NUM_READ_PORTS-1:0]              port_en;

  // Memory side buses, slice m belongs to memory m
  logic [NUM_MEMORIES-1:0]            mem_write;
  logic [NUM_MEMORIES*ADDR_WIDTH-1:0] mem_write_addr;
  logic [NUM_MEMORIES*DATA_WIDTH-1:0] mem_write_data;
  logic [NUM_MEMORIES-1:0]            mem_read;
  logic [NUM_MEMORIES*ADDR_WIDTH-1:0] mem_read_addr;
  logic [NUM_MEMORIES*DATA_WIDTH-1:0] mem_data;
  logic [NUM_MEMORIES-1:0]            mem_valid;

  port_map #(
    .NUM_MEMORIES    (NUM_MEMORIES),
    .NUM_READ_PORTS  (NUM_READ_PORTS),
    .NUM_WRITE_PORTS (NUM_WRITE_PORTS)
  ) u_port_map (
    .clk           (clk),
    .rst           (rst),
    .cmd_assign    (cmd_assign),
    .cmd_unassign  (cmd_unassign),
    .memory        (memory),
    .read_port     (read_port),
    .write_port    (write_port),
    .mem_read_sel  (mem_read_sel),
    .mem_read_en   (mem_read_en),
    .mem_write_sel (mem_write_sel),
    .mem_write_en  (mem_write_en),
    .port_mem_sel  (port_mem_sel),
    .port_en       (port_en)
  );

  write_switch #(
    .DATA_WIDTH      (DATA_WIDTH),
    .ADDR_WIDTH      (ADDR_WIDTH),
    .NUM_MEMORIES    (NUM_MEMORIES),
    .NUM_WRITE_PORTS (NUM_WRITE_PORTS)
  ) u_write_switch (
    .mem_write_sel  (mem_write_sel),
    .mem_write_en   (mem_write_en),
    .write_in       (write_in),
    .write_addr_in  (write_addr_in),
    .write_data_in  (write_data_in),
    .mem_write      (mem_write),
    .mem_write_addr (mem_write_addr),
    .mem_write_data (mem_write_data)
  );

  read_switch #(
    .DATA_WIDTH     (DATA_WIDTH),
    .ADDR_WIDTH     (ADDR_WIDTH),
    .NUM_MEMORIES   (NUM_MEMORIES),
    .NUM_READ_PORTS (NUM_READ_PORTS)
  ) u_read_switch (
    .mem_read_sel   (mem_read_sel),
    .mem_read_en    (mem_read_en),
    .port_mem_sel   (port_mem_sel),
    .port_en        (port_en),
    .read_in        (read_in),
    .read_addr_in   (read_addr_in),
    .mem_data       (mem_data),
    .mem_valid      (mem_valid),
    .mem_read       (mem_read),
    .mem_read_addr  (mem_read_addr),
    .read_data_out  (read_data_out),
    .read_valid_out (read_valid_out)
  );

  // ------------------------------------------------------------------------
  // Memory array
  // ------------------------------------------------------------------------
  for (genvar m = 0; m < NUM_MEMORIES; m++) begin : g_mem
    bank_memory #(
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem (
      .clk        (clk),
      .rst        (rst),
      .write      (mem_write[m]),
      .addr_write (mem_write_addr[m*ADDR_WIDTH +: ADDR_WIDTH]),
      .data_write (mem_write_data[m*DATA_WIDTH +: DATA_WIDTH]),
      .read       (mem_read[m]),
      .addr_read  (mem_read_addr[m*ADDR_WIDTH +: ADDR_WIDTH]),
      .data_read  (mem_data[m*DATA_WIDTH +: DATA_WIDTH]),
      .valid_out  (mem_valid[m])
    );
  end

endmodule

// ==== bench/memory_bank_tb.sv ====
/*
 * Testbench of the memory bank
 * Maps memories to ports, writes and reads through them, and checks each read
 * port against a shadow model with concurrent assertions
 */

`timescale 1ns/1ps

module memory_bank_tb;
  import bank_pkg::*;

  localparam int DW = DEF_DATA_WIDTH;
  localparam int AW = DEF_ADDR_WIDTH;
  localparam int NM = DEF_NUM_MEMORIES;
  localparam int NRP = DEF_NUM_READ_PORTS;
  localparam int NWP = DEF_NUM_WRITE_PORTS;
  localparam int DEPTH = 2 ** AW;
  localparam int MEM_ID_W = (NM > 1) ? $clog2(NM) : 1;
  localparam int RD_ID_W = (NRP > 1) ? $clog2(NRP) : 1;
  localparam int WR_ID_W = (NWP > 1) ? $clog2(NWP) : 1;

  localparam int RESET_CYCLES = 4;
  localparam int NUM_FILL = 32;                 // Addresses written before the read burst
  localparam int NUM_OPS = 200;                 // Back-to-back read cycles
  localparam int STIM_CYCLES = RESET_CYCLES + 60 + NUM_FILL + NUM_OPS;  // 60 for directed tests
  localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  cmd_assign;
  logic                  cmd_unassign;
  logic [MEM_ID_W-1:0]   memory;
  logic [RD_ID_W-1:0]    read_port;
  logic [WR_ID_W-1:0]    write_port;
  logic [NWP-1:0]        write_in;
  logic [NWP*AW-1:0]     write_addr_in;
  logic [NWP*DW-1:0]     write_data_in;
  logic [NRP-1:0]        read_in;
  logic [NRP*AW-1:0]     read_addr_in;
  logic [NRP*DW-1:0]     read_data_out;
  logic [NRP-1:0]        read_valid_out;

  // ------------------------------------------------------------------------
  // Shadow model
  // ------------------------------------------------------------------------
  logic [DW-1:0] shadow [NM][DEPTH];            // Words written into each memory
  bit            known [NM][DEPTH];             // Word has been written
  int            m_rd_sel [NM];                 // Mapping tables as the commands set them
  bit            m_rd_en [NM];
  int            m_wr_sel [NM];
  bit            m_wr_en [NM];
  int            p_mem [NRP];
  bit            p_en [NRP];
  logic [DW+1:0] exp_q [NRP][$];                // {check data, valid, data} per read
  logic [NRP-1:0] head_valid;                   // Expected result now on the port
  logic [NRP-1:0] head_check;
  logic [DW-1:0] head_data [NRP];

  // Inputs collected for the next cycle
  logic [NWP-1:0]    st_write;
  logic [NWP*AW-1:0] st_waddr;
  logic [NWP*DW-1:0] st_wdata;
  logic [NRP-1:0]    st_read;
  logic [NRP*AW-1:0] st_raddr;

  logic [31:0]   rng_state = 32'd82676;
  int            cycle_count = 0;
  logic [AW-1:0] fill_addr [NUM_FILL];

  memory_bank #(
    .DATA_WIDTH      (DW),
    .ADDR_WIDTH      (AW),
    .NUM_MEMORIES    (NM),
    .NUM_READ_PORTS  (NRP),
    .NUM_WRITE_PORTS (NWP)
  ) uut (
    .clk            (clk),
    .rst            (rst),
    .cmd_assign     (cmd_assign),
    .cmd_unassign   (cmd_unassign),
    .memory         (memory),
    .read_port      (read_port),
    .write_port     (write_port),
    .write_in       (write_in),
    .write_addr_in  (write_addr_in),
    .write_data_in  (write_data_in),
    .read_in        (read_in),
    .read_addr_in   (read_addr_in),
    .read_data_out  (read_data_out),
    .read_valid_out (read_valid_out)
  );

  always #10 clk = ~clk;                        // 20 ns period

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Test timed out after %0d cycles without finishing", cycle_count);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);                          // xorshift32
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function automatic void stage_write(int wp, logic [AW-1:0] addr, logic [DW-1:0] data);
    st_write[wp] = 1'b1;
    st_waddr[wp*AW +: AW] = addr;
    st_wdata[wp*DW +: DW] = data;
  endfunction

  function automatic void request_read(int rp, logic [AW-1:0] addr);
    st_read[rp] = 1'b1;
    st_raddr[rp*AW +: AW] = addr;
  endfunction

  // Drives one cycle of staged reads and writes and updates the model
  task automatic commit_cycle();
    logic [DW+1:0] entry;
    logic [AW-1:0] a;
    int m;
    @(posedge clk);
    for (int p = 0; p < NRP; p++) begin        // Reads first, they see the old words
      if (st_read[p]) begin
        m = p_mem[p];
        a = st_raddr[p*AW +: AW];
        if (!p_en[p]) begin
          entry = {1'b1, 1'b0, {DW{1'b0}}};     // Idle port gives zero
        end else if (m_rd_en[m] && m_rd_sel[m] == p) begin
          entry = {known[m][a], 1'b1, shadow[m][a]};
        end else begin
          entry = {1'b0, 1'b0, {DW{1'b0}}};
        end
        exp_q[p].push_back(entry);
      end
    end
    for (m = 0; m < NM; m++) begin
      if (m_wr_en[m] && st_write[m_wr_sel[m]]) begin   // Every memory on the port takes it
        a = st_waddr[m_wr_sel[m]*AW +: AW];
        shadow[m][a] = st_wdata[m_wr_sel[m]*DW +: DW];
        known[m][a] = 1'b1;
      end
    end
    write_in <= st_write;
    write_addr_in <= st_waddr;
    write_data_in <= st_wdata;
    read_in <= st_read;
    read_addr_in <= st_raddr;
    st_write = '0;
    st_read = '0;
  endtask

  task automatic idle_cycles(int n);
    repeat (n) commit_cycle();
  endtask

  // One cycle strobe, mapping visible from the following edge
  task automatic send_command(bit asg, bit unasg, int mem, int rp, int wp);
    @(posedge clk);
    cmd_assign <= asg;
    cmd_unassign <= unasg;
    memory <= MEM_ID_W'(mem);
    read_port <= RD_ID_W'(rp);
    write_port <= WR_ID_W'(wp);
    write_in <= '0;
    read_in <= '0;
    if (asg) begin                              // Assign wins
      m_rd_sel[mem] = rp;
      m_wr_sel[mem] = wp;
      m_rd_en[mem] = 1'b1;
      m_wr_en[mem] = 1'b1;
      p_mem[rp] = mem;
      p_en[rp] = 1'b1;
    end else if (unasg) begin
      m_rd_en[mem] = 1'b0;
      m_wr_en[mem] = 1'b0;
      p_en[rp] = 1'b0;
    end
    @(posedge clk);
    cmd_assign <= 1'b0;
    cmd_unassign <= 1'b0;
  endtask

  // ------------------------------------------------------------------------
  // Result checking
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    logic [DW+1:0] entry;
    if (!rst) begin
      head_valid <= '0;
      head_check <= '0;
    end else begin
      for (int p = 0; p < NRP; p++) begin
        if (read_in[p]) begin                   // Strobe taken now, result after this edge
          entry = exp_q[p].pop_front();
          head_check[p] <= entry[DW+1];
          head_valid[p] <= entry[DW];
          head_data[p] <= entry[DW-1:0];
        end else begin
          head_check[p] <= 1'b0;
          head_valid[p] <= 1'b0;
        end
      end
    end
  end

  for (genvar p = 0; p < NRP; p++) begin : g_check
    property p_read_result;
      @(posedge clk) disable iff (!rst)
        (read_valid_out[p] == head_valid[p]) &&
        (!head_check[p] || read_data_out[p*DW +: DW] == head_data[p]);
    endproperty

    a_read_result : assert property (p_read_result) else begin
      $display("Error at %0t ns: read port %0d gave valid %b data %h, expected valid %b data %h",
        $time, p, $sampled(read_valid_out[p]), $sampled(read_data_out[p*DW +: DW]),
        $sampled(head_valid[p]), $sampled(head_data[p]));
      $display("STATUS: FAIL");
      $fatal(1, "read result mismatch");
    end
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [AW-1:0] a0;
    logic [AW-1:0] a1;
    logic [DW-1:0] d0;
    logic [DW-1:0] d1;
    logic [31:0] r;
    rst <= 1'b0;
    cmd_assign <= 1'b0;
    cmd_unassign <= 1'b0;
    memory <= '0;
    read_port <= '0;
    write_port <= '0;
    write_in <= '0;
    write_addr_in <= '0;
    write_data_in <= '0;
    read_in <= '0;
    read_addr_in <= '0;
    st_write = '0;
    st_waddr = '0;
    st_wdata = '0;
    st_read = '0;
    st_raddr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;

    idle_cycles(2);                             // No mapping yet, ports read zero
    request_read(0, AW'(next_random()));
    request_read(1, AW'(next_random()));
    commit_cycle();

    send_command(1'b1, 1'b0, 0, 0, 0);          // Memory 0 on read 0, write 0
    a0 = AW'(next_random());
    d0 = DW'(next_random());
    d1 = DW'(next_random());
    stage_write(0, a0, d0);
    commit_cycle();
    request_read(0, a0);
    commit_cycle();
    stage_write(0, a0, d1);                     // Same cycle read returns d0
    request_read(0, a0);
    commit_cycle();
    request_read(0, a0);
    idle_cycles(2);

    send_command(1'b1, 1'b0, 1, 1, 1);          // Memory 1 on read 1, write 1
    a0 = AW'(next_random());
    stage_write(0, a0, DW'(next_random()));
    stage_write(1, a0, DW'(next_random()));
    commit_cycle();
    request_read(0, a0);
    request_read(1, a0);
    idle_cycles(2);

    send_command(1'b1, 1'b0, 2, 0, 0);          // Memories 0 and 2 share write 0
    a1 = AW'(next_random());
    d0 = DW'(next_random());
    stage_write(0, a1, d0);
    commit_cycle();
    request_read(0, a1);
    commit_cycle();
    send_command(1'b1, 1'b0, 0, 0, 0);
    request_read(0, a1);
    commit_cycle();
    send_command(1'b1, 1'b0, 2, 0, 0);
    request_read(0, a1);
    idle_cycles(2);

    send_command(1'b0, 1'b1, 2, 0, 0);          // Port 0 idle, memory 2 off write 0
    request_read(0, a1);
    commit_cycle();
    d1 = DW'(next_random());
    stage_write(0, a1, d1);                     // Reaches memory 0 only
    commit_cycle();
    send_command(1'b1, 1'b0, 2, 0, 0);
    request_read(0, a1);
    commit_cycle();
    send_command(1'b1, 1'b0, 0, 0, 0);
    request_read(0, a1);
    idle_cycles(2);

    for (int i = 0; i < NUM_FILL; i++) begin   // Memory 0 on port 0, memory 1 on port 1
      fill_addr[i] = AW'(next_random());
      stage_write(0, fill_addr[i], DW'(next_random()));
      stage_write(1, fill_addr[i], DW'(next_random()));
      commit_cycle();
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      request_read(0, fill_addr[int'(next_random() % 32'(NUM_FILL))]);
      request_read(1, fill_addr[int'(next_random() % 32'(NUM_FILL))]);
      r = next_random();
      if (r[0]) begin                           // Overwrite while reads are in flight
        stage_write(0, fill_addr[int'(r % 32'(NUM_FILL))], DW'(next_random()));
      end
      commit_cycle();
    end
    idle_cycles(3);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== memory_bank.f ====
logic/bank_pkg.sv
logic/port_map.sv
logic/write_switch.sv
logic/bank_memory.sv
logic/read_switch.sv
logic/memory_bank.sv
bench/memory_bank_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory bank testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memory_bank_tb
FILELIST  = memory_bank.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
